/* include/glb_settings.svh */
////////////////////////////////////////
// sizes are fixed by the address layout
// GLB_ADDR_WIDTH = 1 + tile bits + word bits
////////////////////////////////////////
`ifndef GLB_SETTINGS_SVH
`define GLB_SETTINGS_SVH

// one bank per tile
`define GLB_NUM_TILES 4

// bank word and stream word
`define GLB_BANK_DATA_WIDTH 64
`define GLB_CGRA_DATA_WIDTH 16

// bank word width over stream word width
`define GLB_WORDS_PER_PACK 4

// 256 words per bank
`define GLB_BANK_ADDR_WIDTH 8
`define GLB_TILE_SEL_WIDTH 2

// region bit, tile bits, word index
`define GLB_ADDR_WIDTH 11

`endif

/* src/glb_pkg.sv */
////////////////////////////////////////
// address views and stream register indices
// reg index 3 is unassigned and ignored on write
////////////////////////////////////////
`include "glb_settings.svh"

package glb_pkg;

    // stream register selected by the cfg view
    typedef enum logic [1:0] {
        REG_BASE  = 2'd0,
        REG_COUNT = 2'd1,
        REG_CLEAR = 2'd2
    } glb_reg_e;

    // one processor word address
    // region 0 is bank memory and region 1 the stream registers
    typedef union packed {
        struct packed {
            logic                               region;
            logic [`GLB_TILE_SEL_WIDTH-1:0]     tile;
            logic [`GLB_BANK_ADDR_WIDTH-1:0]    word;
        } mem;
        struct packed {
            logic                               region;
            logic [`GLB_TILE_SEL_WIDTH-1:0]     tile;
            // padding up to the reg field
            logic [`GLB_BANK_ADDR_WIDTH-3:0]    unused;
            glb_reg_e                           reg_idx;
        } cfg;
    } glb_addr_u;

endpackage

/* src/glb_proc_router.sv */
////////////////////////////////////////
// strobes have no back-pressure and one request is taken per cycle
// writes land one cycle after the strobe and reads return two after
////////////////////////////////////////
`timescale 1ns/10ps
`include "glb_settings.svh"

module glb_proc_router (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                wr_en,
    input  logic [`GLB_BANK_DATA_WIDTH/8-1:0]   wr_strb,
    input  glb_pkg::glb_addr_u                  wr_addr,
    input  logic [`GLB_BANK_DATA_WIDTH-1:0]     wr_data,
    input  logic                                rd_en,
    input  glb_pkg::glb_addr_u                  rd_addr,
    output logic [`GLB_BANK_DATA_WIDTH-1:0]     rd_data,
    output logic                                bank_wr_en [`GLB_NUM_TILES],
    output logic [`GLB_BANK_DATA_WIDTH/8-1:0]   bank_wr_strb,
    output logic [`GLB_BANK_ADDR_WIDTH-1:0]     bank_wr_addr,
    output logic [`GLB_BANK_DATA_WIDTH-1:0]     bank_wr_data,
    output logic                                bank_rd_en [`GLB_NUM_TILES],
    output logic [`GLB_BANK_ADDR_WIDTH-1:0]     bank_rd_addr,
    input  logic [`GLB_BANK_DATA_WIDTH-1:0]     bank_rd_data [`GLB_NUM_TILES],
    output logic                                reg_wr_en [`GLB_NUM_TILES],
    output glb_pkg::glb_reg_e                   reg_sel,
    output logic [`GLB_BANK_DATA_WIDTH-1:0]     reg_wr_data,
    input  logic                                status_done [`GLB_NUM_TILES]
);
    import glb_pkg::*;

    logic [`GLB_BANK_DATA_WIDTH-1:0]    wr_data_q;

    // read request stage
    logic                               rd_vld_q;
    logic                               rd_region_q;
    logic [`GLB_TILE_SEL_WIDTH-1:0]     rd_tile_q;
    logic                               rd_status_q;

    // return stage, selects what drives rd_data
    logic                               ret_region;
    logic [`GLB_TILE_SEL_WIDTH-1:0]     ret_tile;
    logic                               ret_status;

    // per-tile strobes
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int t = 0; t < `GLB_NUM_TILES; t++) begin
                bank_wr_en[t] <= 1'b0;
                bank_rd_en[t] <= 1'b0;
                reg_wr_en[t]  <= 1'b0;
            end
        end else begin
            for (int t = 0; t < `GLB_NUM_TILES; t++) begin
                bank_wr_en[t] <= wr_en && !wr_addr.mem.region
                                 && int'(wr_addr.mem.tile) == t;
                reg_wr_en[t]  <= wr_en && wr_addr.cfg.region
                                 && int'(wr_addr.cfg.tile) == t;
                bank_rd_en[t] <= rd_en && !rd_addr.mem.region
                                 && int'(rd_addr.mem.tile) == t;
            end
        end
    end

    // request payload
    always_ff @(posedge clk) begin
        if (wr_en) begin
            bank_wr_strb <= wr_strb;
            bank_wr_addr <= wr_addr.mem.word;
            reg_sel      <= wr_addr.cfg.reg_idx;
            wr_data_q    <= wr_data;
        end
        if (rd_en) begin
            bank_rd_addr <= rd_addr.mem.word;
            rd_region_q  <= rd_addr.mem.region;
            rd_tile_q    <= rd_addr.mem.tile;
            // done of the addressed tile at request time
            rd_status_q  <= status_done[rd_addr.cfg.tile];
        end
    end

    // bank and register writes share one data register
    assign bank_wr_data = wr_data_q;
    assign reg_wr_data  = wr_data_q;

    // idles on the status view so rd_data is zero out of reset
    always_ff @(posedge clk) begin
        if (rst) begin
            rd_vld_q   <= 1'b0;
            ret_region <= 1'b1;
            ret_tile   <= '0;
            ret_status <= 1'b0;
        end else begin
            rd_vld_q <= rd_en;
            if (rd_vld_q) begin
                ret_region <= rd_region_q;
                ret_tile   <= rd_tile_q;
                ret_status <= rd_status_q;
            end
        end
    end

    // bank outputs hold between reads so the mux holds too
    assign rd_data = ret_region ? {{(`GLB_BANK_DATA_WIDTH-1){1'b0}}, ret_status}
                                : bank_rd_data[ret_tile];

endmodule

/* src/glb_stream_writer.sv */
////////////////////////////////////////
// packs four stream words per bank word with word 0 lowest
// a count of zero leaves the tile unarmed
////////////////////////////////////////
`timescale 1ns/10ps
`include "glb_settings.svh"

module glb_stream_writer (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                reg_wr_en,
    input  glb_pkg::glb_reg_e                   reg_sel,
    input  logic [`GLB_BANK_DATA_WIDTH-1:0]     reg_wr_data,
    input  logic [`GLB_CGRA_DATA_WIDTH-1:0]     stream_data,
    input  logic                                stream_valid,
    output logic                                pack_wr_en,
    output logic [`GLB_BANK_ADDR_WIDTH-1:0]     pack_wr_addr,
    output logic [`GLB_BANK_DATA_WIDTH-1:0]     pack_wr_data,
    output logic                                done
);
    import glb_pkg::*;

    logic [`GLB_BANK_ADDR_WIDTH-1:0]                        base_q;
    logic [`GLB_BANK_ADDR_WIDTH:0]                          count_q;
    logic                                                   armed;
    logic [`GLB_BANK_DATA_WIDTH-`GLB_CGRA_DATA_WIDTH-1:0]   pack_sr;
    logic [$clog2(`GLB_WORDS_PER_PACK)-1:0]                 pack_cnt;
    logic [`GLB_BANK_ADDR_WIDTH:0]                          pack_num;
    logic [`GLB_BANK_ADDR_WIDTH-1:0]                        wr_ptr;
    logic                                                   arm;
    logic                                                   clear;
    logic                                                   accept;
    logic                                                   word_last;
    logic                                                   pack_last;

    assign arm   = reg_wr_en && reg_sel == REG_COUNT;
    assign clear = reg_wr_en && reg_sel == REG_CLEAR;

    // arming or clearing in the same cycle drops the stream word
    assign accept    = stream_valid && armed && !done && !arm && !clear;
    assign word_last = int'(pack_cnt) == `GLB_WORDS_PER_PACK - 1;
    assign pack_last = pack_num == count_q - 1'b1;

    always_ff @(posedge clk) begin
        if (rst) begin
            base_q     <= '0;
            count_q    <= '0;
            armed      <= 1'b0;
            done       <= 1'b0;
            pack_cnt   <= '0;
            pack_num   <= '0;
            wr_ptr     <= '0;
            pack_wr_en <= 1'b0;
        end else begin
            pack_wr_en <= 1'b0;
            if (reg_wr_en && reg_sel == REG_BASE) begin
                base_q <= reg_wr_data[`GLB_BANK_ADDR_WIDTH-1:0];
            end
            // restart from base with an empty pack
            if (arm) begin
                count_q  <= reg_wr_data[`GLB_BANK_ADDR_WIDTH:0];
                armed    <= |reg_wr_data[`GLB_BANK_ADDR_WIDTH:0];
                wr_ptr   <= base_q;
                pack_cnt <= '0;
                pack_num <= '0;
            end
            if (clear) begin
                armed <= 1'b0;
                done  <= 1'b0;
            end
            if (accept) begin
                pack_cnt <= pack_cnt + 1'b1;
                if (word_last) begin
                    pack_cnt   <= '0;
                    pack_wr_en <= 1'b1;
                    wr_ptr     <= wr_ptr + 1'b1;
                    pack_num   <= pack_num + 1'b1;
                    // sticky until REG_CLEAR
                    if (pack_last) begin
                        done <= 1'b1;
                    end
                end
            end
        end
    end

    // newest word enters at the top and shifts down
    always_ff @(posedge clk) begin
        if (accept) begin
            pack_sr <= {stream_data,
                        pack_sr[`GLB_BANK_DATA_WIDTH-`GLB_CGRA_DATA_WIDTH-1:`GLB_CGRA_DATA_WIDTH]};
            if (word_last) begin
                pack_wr_addr <= wr_ptr;
                pack_wr_data <= {stream_data, pack_sr};
            end
        end
    end

endmodule

/* src/glb_bank.sv */
////////////////////////////////////////
// contents are undefined after reset
// a stream write beats a processor write to the same word
////////////////////////////////////////
`timescale 1ns/10ps
`include "glb_settings.svh"

module glb_bank (
    input  logic                                clk,
    input  logic                                proc_wr_en,
    input  logic [`GLB_BANK_DATA_WIDTH/8-1:0]   proc_wr_strb,
    input  logic [`GLB_BANK_ADDR_WIDTH-1:0]     proc_wr_addr,
    input  logic [`GLB_BANK_DATA_WIDTH-1:0]     proc_wr_data,
    input  logic                                proc_rd_en,
    input  logic [`GLB_BANK_ADDR_WIDTH-1:0]     proc_rd_addr,
    output logic [`GLB_BANK_DATA_WIDTH-1:0]     proc_rd_data,
    input  logic                                pack_wr_en,
    input  logic [`GLB_BANK_ADDR_WIDTH-1:0]     pack_wr_addr,
    input  logic [`GLB_BANK_DATA_WIDTH-1:0]     pack_wr_data
);

    logic [`GLB_BANK_DATA_WIDTH-1:0]    mem [2**`GLB_BANK_ADDR_WIDTH];
    logic                               collide;
    logic                               proc_wr_keep;

    // both ports on one word
    assign collide      = proc_wr_en && pack_wr_en && proc_wr_addr == pack_wr_addr;
    assign proc_wr_keep = proc_wr_en && !collide;

    // old contents on a same-cycle write
    // output holds when no read
    always_ff @(posedge clk) begin
        if (proc_rd_en) begin
            proc_rd_data <= mem[proc_rd_addr];
        end
    end

    // byte-masked processor port
    always_ff @(posedge clk) begin
        if (proc_wr_keep) begin
            for (int b = 0; b < `GLB_BANK_DATA_WIDTH/8; b++) begin
                if (proc_wr_strb[b]) begin
                    mem[proc_wr_addr][b*8 +: 8] <= proc_wr_data[b*8 +: 8];
                end
            end
        end
        // full word from the stream writer
        if (pack_wr_en) begin
            mem[pack_wr_addr] <= pack_wr_data;
        end
    end

endmodule

/* src/glb_top.sv */
////////////////////////////////////////
// tiles are reached by address decode only
// interrupt is a level held while any tile is done
////////////////////////////////////////
`timescale 1ns/10ps
`include "glb_settings.svh"

module glb_top (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                proc2glb_wr_en,
    input  logic [`GLB_BANK_DATA_WIDTH/8-1:0]   proc2glb_wr_strb,
    input  logic [`GLB_ADDR_WIDTH-1:0]          proc2glb_wr_addr,
    input  logic [`GLB_BANK_DATA_WIDTH-1:0]     proc2glb_wr_data,
    input  logic                                proc2glb_rd_en,
    input  logic [`GLB_ADDR_WIDTH-1:0]          proc2glb_rd_addr,
    output logic [`GLB_BANK_DATA_WIDTH-1:0]     glb2proc_rd_data,
    input  logic [`GLB_CGRA_DATA_WIDTH-1:0]     stream_data_f2g [`GLB_NUM_TILES],
    input  logic                                stream_data_valid_f2g [`GLB_NUM_TILES],
    output logic                                interrupt
);
    import glb_pkg::*;

    // router to tiles
    logic                               bank_wr_en [`GLB_NUM_TILES];
    logic [`GLB_BANK_DATA_WIDTH/8-1:0]  bank_wr_strb;
    logic [`GLB_BANK_ADDR_WIDTH-1:0]    bank_wr_addr;
    logic [`GLB_BANK_DATA_WIDTH-1:0]    bank_wr_data;
    logic                               bank_rd_en [`GLB_NUM_TILES];
    logic [`GLB_BANK_ADDR_WIDTH-1:0]    bank_rd_addr;
    logic                               reg_wr_en [`GLB_NUM_TILES];
    glb_reg_e                           reg_sel;
    logic [`GLB_BANK_DATA_WIDTH-1:0]    reg_wr_data;

    // tiles back to router
    logic [`GLB_BANK_DATA_WIDTH-1:0]    bank_rd_data [`GLB_NUM_TILES];
    logic                               status_done [`GLB_NUM_TILES];
    logic                               any_done;

    glb_proc_router glb_proc_router_inst (
        .clk          (clk),
        .rst          (rst),
        .wr_en        (proc2glb_wr_en),
        .wr_strb      (proc2glb_wr_strb),
        .wr_addr      (proc2glb_wr_addr),
        .wr_data      (proc2glb_wr_data),
        .rd_en        (proc2glb_rd_en),
        .rd_addr      (proc2glb_rd_addr),
        .rd_data      (glb2proc_rd_data),
        .bank_wr_en   (bank_wr_en),
        .bank_wr_strb (bank_wr_strb),
        .bank_wr_addr (bank_wr_addr),
        .bank_wr_data (bank_wr_data),
        .bank_rd_en   (bank_rd_en),
        .bank_rd_addr (bank_rd_addr),
        .bank_rd_data (bank_rd_data),
        .reg_wr_en    (reg_wr_en),
        .reg_sel      (reg_sel),
        .reg_wr_data  (reg_wr_data),
        .status_done  (status_done)
    );

    generate
    for (genvar t = 0; t < `GLB_NUM_TILES; t++) begin : tile_gen
        // stream writer to bank
        logic                               pack_wr_en;
        logic [`GLB_BANK_ADDR_WIDTH-1:0]    pack_wr_addr;
        logic [`GLB_BANK_DATA_WIDTH-1:0]    pack_wr_data;

        glb_stream_writer glb_stream_writer_inst (
            .clk          (clk),
            .rst          (rst),
            .reg_wr_en    (reg_wr_en[t]),
            .reg_sel      (reg_sel),
            .reg_wr_data  (reg_wr_data),
            .stream_data  (stream_data_f2g[t]),
            .stream_valid (stream_data_valid_f2g[t]),
            .pack_wr_en   (pack_wr_en),
            .pack_wr_addr (pack_wr_addr),
            .pack_wr_data (pack_wr_data),
            .done         (status_done[t])
        );

        glb_bank glb_bank_inst (
            .clk          (clk),
            .proc_wr_en   (bank_wr_en[t]),
            .proc_wr_strb (bank_wr_strb),
            .proc_wr_addr (bank_wr_addr),
            .proc_wr_data (bank_wr_data),
            .proc_rd_en   (bank_rd_en[t]),
            .proc_rd_addr (bank_rd_addr),
            .proc_rd_data (bank_rd_data[t]),
            .pack_wr_en   (pack_wr_en),
            .pack_wr_addr (pack_wr_addr),
            .pack_wr_data (pack_wr_data)
        );
    end : tile_gen
    endgenerate

    always_comb begin
        any_done = 1'b0;
        for (int t = 0; t < `GLB_NUM_TILES; t++) begin
            any_done = any_done | status_done[t];
        end
    end

    // one cycle behind the done flags
    always_ff @(posedge clk) begin
        if (rst) begin
            interrupt <= 1'b0;
        end else begin
            interrupt <= any_done;
        end
    end

endmodule

/* tests/glb_asserts.sv */
////////////////////////////////////////
// protocol checks bound into glb_top
// err_count counts every failed assertion
////////////////////////////////////////
`timescale 1ns/10ps
`include "glb_settings.svh"

module glb_top_asserts (
    input  logic                clk,
    input  logic                rst,
    input  logic                interrupt,
    input  logic                status_done [`GLB_NUM_TILES],
    input  logic                reg_wr_en [`GLB_NUM_TILES],
    input  glb_pkg::glb_reg_e   reg_sel
);
    import glb_pkg::*;

    int unsigned    err_count = 0;
    logic           any_done;

    always_comb begin
        any_done = 1'b0;
        for (int t = 0; t < `GLB_NUM_TILES; t++) begin
            any_done = any_done | status_done[t];
        end
    end

    // quiet through reset and the cycle after
    irq_reset_low: assert property (@(posedge clk) rst |=> !interrupt ##1 !interrupt)
        else begin
            err_count++;
            $error("interrupt high during or just after reset");
        end

    // registered OR of the done flags
    irq_needs_done: assert property (@(posedge clk) disable iff (rst)
                                     $rose(interrupt) |-> $past(any_done))
        else begin
            err_count++;
            $error("interrupt rose with no tile done");
        end

    for (genvar t = 0; t < `GLB_NUM_TILES; t++) begin : done_gen
        done_sticky: assert property (@(posedge clk) $fell(status_done[t]) |->
                                      $past(rst || (reg_wr_en[t] && reg_sel == REG_CLEAR)))
            else begin
                err_count++;
                $error("done of tile %0d fell without a clear or reset", t);
            end
    end : done_gen

endmodule

bind glb_top glb_top_asserts glb_top_asserts_inst (
    .clk         (clk),
    .rst         (rst),
    .interrupt   (interrupt),
    .status_done (status_done),
    .reg_wr_en   (reg_wr_en),
    .reg_sel     (reg_sel)
);

/* tests/glb_tb.sv */
////////////////////////////////////////
// inputs change on the falling edge
// assertions stop the run at the first mismatch
// random stimulus from seed 31
////////////////////////////////////////
`timescale 1ns/10ps
`include "glb_settings.svh"

module glb_tb;
    import glb_pkg::*;

    localparam int CLK_PERIOD    = 10;
    localparam int INIT_WORDS    = 8;
    localparam int RAND_OPS      = 32;
    localparam int MAX_COUNT     = 4;
    localparam int MAX_GAP       = 2;
    localparam int PROC_CYCLES   = `GLB_NUM_TILES * INIT_WORDS + 2 * RAND_OPS + INIT_WORDS;
    localparam int STREAM_CYCLES = `GLB_NUM_TILES
                                   * (24 + MAX_COUNT * `GLB_WORDS_PER_PACK * (MAX_GAP + 1));
    localparam int TEST_CYCLES   = 60 + PROC_CYCLES + STREAM_CYCLES;

    logic                               clk;
    logic                               rst;
    logic                               proc2glb_wr_en;
    logic [`GLB_BANK_DATA_WIDTH/8-1:0]  proc2glb_wr_strb;
    glb_addr_u                          proc2glb_wr_addr;
    logic [`GLB_BANK_DATA_WIDTH-1:0]    proc2glb_wr_data;
    logic                               proc2glb_rd_en;
    glb_addr_u                          proc2glb_rd_addr;
    logic [`GLB_BANK_DATA_WIDTH-1:0]    glb2proc_rd_data;
    logic [`GLB_CGRA_DATA_WIDTH-1:0]    stream_data_f2g [`GLB_NUM_TILES];
    logic                               stream_data_valid_f2g [`GLB_NUM_TILES];
    logic                               interrupt;

    // reference model
    logic [`GLB_BANK_DATA_WIDTH-1:0]    ref_mem [`GLB_NUM_TILES][2**`GLB_BANK_ADDR_WIDTH];
    logic [`GLB_BANK_DATA_WIDTH-1:0]    ref_pack [`GLB_NUM_TILES];
    logic [`GLB_NUM_TILES-1:0]          ref_armed;
    logic [`GLB_NUM_TILES-1:0]          exp_done;
    logic [`GLB_NUM_TILES-1:0]          clear_pend;
    int                                 ref_base [`GLB_NUM_TILES];
    int                                 ref_ptr [`GLB_NUM_TILES];
    int                                 ref_left [`GLB_NUM_TILES];
    int                                 ref_words [`GLB_NUM_TILES];

    // expected read data with the cycle it is due
    logic [`GLB_BANK_DATA_WIDTH-1:0]    exp_rd_q [$];
    int                                 due_q [$];
    logic [`GLB_BANK_DATA_WIDTH-1:0]    chk_word;
    int                                 cyc = 0;

    glb_top glb_top_inst (
        .clk                   (clk),
        .rst                   (rst),
        .proc2glb_wr_en        (proc2glb_wr_en),
        .proc2glb_wr_strb      (proc2glb_wr_strb),
        .proc2glb_wr_addr      (proc2glb_wr_addr),
        .proc2glb_wr_data      (proc2glb_wr_data),
        .proc2glb_rd_en        (proc2glb_rd_en),
        .proc2glb_rd_addr      (proc2glb_rd_addr),
        .glb2proc_rd_data      (glb2proc_rd_data),
        .stream_data_f2g       (stream_data_f2g),
        .stream_data_valid_f2g (stream_data_valid_f2g),
        .interrupt             (interrupt)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    always @(posedge clk) cyc <= cyc + 1;

    task automatic stop_with_fail(input string line);
        $display("%s", line);
        $display("=== FAIL ===");
        $fatal(1, "run stopped at the first failure");
    endtask

    function automatic glb_addr_u bank_addr(input int tile, input int word);
        glb_addr_u a;
        a = '0;
        a.mem.tile = tile[`GLB_TILE_SEL_WIDTH-1:0];
        a.mem.word = word[`GLB_BANK_ADDR_WIDTH-1:0];
        return a;
    endfunction

    function automatic glb_addr_u reg_addr(input int tile, input glb_reg_e r);
        glb_addr_u a;
        a = '0;
        a.cfg.region  = 1'b1;
        a.cfg.tile    = tile[`GLB_TILE_SEL_WIDTH-1:0];
        a.cfg.reg_idx = r;
        return a;
    endfunction

    task automatic issue_write(input glb_addr_u addr, input logic [7:0] strb,
                               input logic [`GLB_BANK_DATA_WIDTH-1:0] data);
        int t;
        t = int'(addr.cfg.tile);
        proc2glb_wr_en   = 1'b1;
        proc2glb_wr_strb = strb;
        proc2glb_wr_addr = addr;
        proc2glb_wr_data = data;
        if (!addr.mem.region) begin
            for (int b = 0; b < `GLB_BANK_DATA_WIDTH/8; b++) begin
                if (strb[b]) begin
                    ref_mem[t][addr.mem.word][b*8 +: 8] = data[b*8 +: 8];
                end
            end
        end else begin
            case (addr.cfg.reg_idx)
                REG_BASE: ref_base[t] = int'(data[`GLB_BANK_ADDR_WIDTH-1:0]);
                REG_COUNT: begin
                    ref_left[t]  = int'(data[`GLB_BANK_ADDR_WIDTH:0]);
                    ref_armed[t] = ref_left[t] != 0;
                    ref_ptr[t]   = ref_base[t];
                    ref_words[t] = 0;
                end
                REG_CLEAR: begin
                    ref_armed[t]  = 1'b0;
                    clear_pend[t] = 1'b1;
                end
                default: ;
            endcase
        end
    endtask

    // call before a write in the same cycle as the bank returns old data
    task automatic request_read(input glb_addr_u addr);
        proc2glb_rd_en   = 1'b1;
        proc2glb_rd_addr = addr;
        if (addr.cfg.region) begin
            exp_rd_q.push_back({{(`GLB_BANK_DATA_WIDTH-1){1'b0}}, exp_done[addr.cfg.tile]});
        end else begin
            exp_rd_q.push_back(ref_mem[addr.mem.tile][addr.mem.word]);
        end
        due_q.push_back(cyc + 2);
    endtask

    task automatic push_stream_word(input int t, input logic [`GLB_CGRA_DATA_WIDTH-1:0] data);
        stream_data_valid_f2g[t] = 1'b1;
        stream_data_f2g[t]       = data;
        if (ref_armed[t] && !exp_done[t]) begin
            ref_pack[t][ref_words[t]*`GLB_CGRA_DATA_WIDTH +: `GLB_CGRA_DATA_WIDTH] = data;
            ref_words[t]++;
            if (ref_words[t] == `GLB_WORDS_PER_PACK) begin
                ref_mem[t][ref_ptr[t]] = ref_pack[t];
                ref_ptr[t]   = (ref_ptr[t] + 1) % 2**`GLB_BANK_ADDR_WIDTH;
                ref_words[t] = 0;
                ref_left[t]--;
                if (ref_left[t] == 0) begin
                    exp_done[t] = 1'b1;
                end
            end
        end
    endtask

    // a clear reaches done one cycle later than a stream word
    task automatic next_cycle();
        @(negedge clk);
        proc2glb_wr_en = 1'b0;
        proc2glb_rd_en = 1'b0;
        for (int t = 0; t < `GLB_NUM_TILES; t++) begin
            stream_data_valid_f2g[t] = 1'b0;
        end
        exp_done   = exp_done & ~clear_pend;
        clear_pend = '0;
    endtask

    task automatic run_proc_traffic();
        glb_addr_u a;
        for (int t = 0; t < `GLB_NUM_TILES; t++) begin
            for (int w = 0; w < INIT_WORDS; w++) begin
                issue_write(bank_addr(t, w), 8'hff, {$urandom, $urandom});
                next_cycle();
            end
        end
        for (int i = 0; i < RAND_OPS; i++) begin
            a = bank_addr($urandom % `GLB_NUM_TILES, $urandom % INIT_WORDS);
            request_read(a);
            issue_write(a, 8'($urandom), {$urandom, $urandom});
            next_cycle();
            request_read(a);
            next_cycle();
        end
        // back to back reads overlap in the router
        for (int i = 0; i < INIT_WORDS; i++) begin
            request_read(bank_addr(i % `GLB_NUM_TILES, i));
            next_cycle();
        end
    endtask

    task automatic run_stream(input int t);
        int base;
        int count;
        base  = 32 + $urandom % 64;
        count = 1 + $urandom % MAX_COUNT;
        // guard word catches writes after done
        issue_write(bank_addr(t, base + count), 8'hff, {$urandom, $urandom});
        next_cycle();
        repeat (`GLB_WORDS_PER_PACK) begin
            push_stream_word(t, 16'($urandom));
            next_cycle();
        end
        issue_write(reg_addr(t, REG_BASE), 8'hff, 64'(base));
        next_cycle();
        issue_write(reg_addr(t, REG_COUNT), 8'hff, 64'(count));
        next_cycle();
        next_cycle();
        for (int i = 0; i < count * `GLB_WORDS_PER_PACK; i++) begin
            repeat ($urandom % (MAX_GAP + 1)) next_cycle();
            push_stream_word(t, 16'($urandom));
            next_cycle();
        end
        repeat (`GLB_WORDS_PER_PACK) begin
            push_stream_word(t, 16'($urandom));
            next_cycle();
        end
        repeat (2) next_cycle();
        for (int i = 0; i <= count; i++) begin
            request_read(bank_addr(t, base + i));
            next_cycle();
        end
        // an unarmed writer points at word 0 out of reset
        request_read(bank_addr(t, 0));
        next_cycle();
        request_read(reg_addr(t, REG_BASE));
        next_cycle();
    endtask

    task automatic check_collision();
        issue_write(reg_addr(0, REG_BASE), 8'hff, 64'h0f0);
        next_cycle();
        issue_write(reg_addr(0, REG_COUNT), 8'hff, 64'd1);
        next_cycle();
        next_cycle();
        repeat (`GLB_WORDS_PER_PACK - 1) begin
            push_stream_word(0, 16'($urandom));
            next_cycle();
        end
        // both ports reach word 0xf0 at the same edge
        issue_write(bank_addr(0, 'hf0), 8'hff, {$urandom, $urandom});
        push_stream_word(0, 16'($urandom));
        next_cycle();
        repeat (2) next_cycle();
        request_read(bank_addr(0, 'hf0));
        next_cycle();
        issue_write(reg_addr(0, REG_CLEAR), 8'hff, '0);
        next_cycle();
    endtask

    // model flags lead the DUT by half a cycle
    irq_check: assert property (@(posedge clk) disable iff (rst)
                                interrupt == $past(|exp_done, 2))
        else stop_with_fail($sformatf("[ERROR] %0t interrupt %b disagrees with the model",
                                      $time, interrupt));

    always @(negedge clk) begin
        if (due_q.size() != 0 && due_q[0] == cyc) begin
            chk_word = exp_rd_q.pop_front();
            void'(due_q.pop_front());
            read_check: assert (glb2proc_rd_data === chk_word)
                else stop_with_fail($sformatf("[ERROR] %0t read data %h, expected %h",
                                              $time, glb2proc_rd_data, chk_word));
        end
        if (glb_top_inst.glb_top_asserts_inst.err_count != 0) begin
            stop_with_fail("a protocol assertion bound to the DUT failed");
        end
    end

    initial begin
        #(2 * TEST_CYCLES * CLK_PERIOD);
        stop_with_fail("timeout, the run did not finish in the expected number of cycles");
    end

    initial begin
        void'($urandom(31));
        clk              = 1'b0;
        rst              = 1'b1;
        proc2glb_wr_en   = 1'b0;
        proc2glb_wr_strb = '0;
        proc2glb_wr_addr = '0;
        proc2glb_wr_data = '0;
        proc2glb_rd_en   = 1'b0;
        proc2glb_rd_addr = '0;
        ref_armed        = '0;
        exp_done         = '0;
        clear_pend       = '0;
        for (int t = 0; t < `GLB_NUM_TILES; t++) begin
            stream_data_f2g[t]       = '0;
            stream_data_valid_f2g[t] = 1'b0;
            ref_base[t]              = 0;
            ref_ptr[t]               = 0;
            ref_left[t]              = 0;
            ref_words[t]             = 0;
        end
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        next_cycle();
        reset_check: assert (glb2proc_rd_data === '0 && interrupt === 1'b0)
            else stop_with_fail($sformatf("[ERROR] %0t outputs not idle after reset", $time));
        run_proc_traffic();
        for (int t = 0; t < `GLB_NUM_TILES; t++) begin
            run_stream(t);
        end
        // interrupt holds until the last tile is cleared
        for (int t = 0; t < `GLB_NUM_TILES; t++) begin
            issue_write(reg_addr(t, REG_CLEAR), 8'hff, '0);
            next_cycle();
            repeat (2) next_cycle();
            request_read(reg_addr(t, REG_COUNT));
            next_cycle();
        end
        check_collision();
        repeat (4) next_cycle();
        if (glb_top_inst.glb_top_asserts_inst.err_count == 0 && due_q.size() == 0) begin
            $display("=== PASS ===");
            $finish;
        end else begin
            stop_with_fail("protocol assertions failed or reads were left unchecked");
        end
    end

endmodule

/* tb.f */
+incdir+include
src/glb_pkg.sv
src/glb_proc_router.sv
src/glb_stream_writer.sv
src/glb_bank.sv
src/glb_top.sv
tests/glb_asserts.sv
tests/glb_tb.sv
